//--- sd_disk_ctrl.f
+incdir+tb
verilog/sd_disk_pkg.sv
verilog/sd_bus_fanout.sv
verilog/block_channel.sv
verilog/sd_bus_merge.sv
verilog/sd_disk_ctrl.sv
tb/sd_disk_ctrl_tb.sv

//--- tb/sd_disk_tb_tasks.svh
/* Stimulus tasks: host requests, SD service emulation with random ack delays,
   host buffer writes and read checks, image mounts */

	// ==============================
	// Host side
	// ==============================

	task automatic pulse_request(input int slot, input bit is_write, input sd_disk_pkg::lba_t lba);
		@(negedge clk_sys);
		host_lba[slot] = lba;
		if (is_write)
			req_write[slot] = 1'b1;
		else
			req_read[slot] = 1'b1;
		@(negedge clk_sys);
		req_read[slot] = 1'b0;
		req_write[slot] = 1'b0;
	endtask

	task automatic host_write(input int slot, input sd_disk_pkg::buf_addr_t addr,
		input sd_disk_pkg::byte_t data);
		@(negedge clk_sys);
		host_chk = '0;
		host_we = '0;
		host_addr[slot] = addr;
		host_wdata[slot] = data;
		host_we[slot] = 1'b1;
		exp_mem[slot][addr] = data;
	endtask

	task automatic host_check(input int slot, input sd_disk_pkg::buf_addr_t addr);
		@(negedge clk_sys);
		host_we = '0;
		host_chk = '0;
		host_addr[slot] = addr;
		host_exp[slot] = exp_mem[slot][addr];
		host_chk[slot] = 1'b1;
	endtask

	task automatic release_host_port();
		@(negedge clk_sys);
		host_we = '0;
		host_chk = '0;
	endtask

	task automatic preload_buffers();
		for (int s = 0; s < num_slots; s++) begin
			for (int a = 0; a < sd_disk_pkg::BUF_DEPTH; a++)
				host_write(s, 9'(a), fill_byte(s, a));
		end
		release_host_port();
	endtask

	// ==============================
	// SD service emulation
	// ==============================

	task automatic wait_request(input int slot, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < req_timeout && !ok; n++) begin
			@(negedge clk_sys);
			ok = sd_rd[slot] | sd_wr[slot];
		end
		if (!ok) begin
			timeouts++;
			$display("Timeout: slot %0d raised no SD request within %0d cycles",
				slot, req_timeout);
		end
	endtask

	task automatic wait_idle();
		bit idle;
		idle = 1'b0;
		for (int n = 0; n < req_timeout && !idle; n++) begin
			@(negedge clk_sys);
			idle = !cpu_wait;
		end
		if (!idle) begin
			timeouts++;
			$display("Timeout: cpu_wait stayed high after the transfer ended");
		end
	endtask

	// Read service, optionally with a repeated host pulse while the ack is high
	task automatic serve_read(input int slot, input int nbytes, input bit repeat_pulse);
		bit ok;
		int delay;
		sd_disk_pkg::buf_addr_t a;
		sd_disk_pkg::byte_t d;
		wait_request(slot, ok);
		if (ok) begin
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) @(negedge clk_sys);
			sd_ack[slot] = 1'b1;
			// Lands after the ack edge has cleared the pending flags
			if (repeat_pulse) begin
				@(negedge clk_sys);
				pulse_request(slot, 1'b0, $random(seed));
			end
			for (int k = 0; k < nbytes; k++) begin
				@(negedge clk_sys);
				a = 9'($random(seed));
				d = 8'($random(seed));
				sd_buff_addr = a;
				sd_buff_dout = d;
				sd_buff_wr = 1'b1;
				exp_mem[slot][a] = d;
				touched.push_back(a);
			end
			@(negedge clk_sys);
			sd_buff_wr = 1'b0;
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) @(negedge clk_sys);
			sd_ack[slot] = 1'b0;
			wait_idle();
		end
	endtask

	// Write service reads back every address the host filled
	task automatic serve_write(input int slot);
		bit ok;
		int delay;
		wait_request(slot, ok);
		if (ok) begin
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) @(negedge clk_sys);
			sd_ack[slot] = 1'b1;
			foreach (touched[k]) begin
				@(negedge clk_sys);
				sd_buff_addr = touched[k];
				sd_exp = exp_mem[slot][touched[k]];
				sd_chk = 1'b1;
			end
			@(negedge clk_sys);
			sd_chk = 1'b0;
			delay = 1 + ($unsigned($random(seed)) % 4);
			repeat (delay) @(negedge clk_sys);
			sd_ack[slot] = 1'b0;
			wait_idle();
		end
	endtask

	task automatic mount_image(input int slot, input sd_disk_pkg::img_size_t size, input bit ro);
		@(negedge clk_sys);
		img_size = size;
		img_readonly = ro;
		img_mounted[slot] = 1'b1;
		chg_model[slot] = ~chg_model[slot];
		@(negedge clk_sys);
		img_mounted = '0;
		repeat (3) @(negedge clk_sys);
	endtask

//--- tb/sd_disk_ctrl_tb.sv
/* Testbench top: clock, reset, test sequence over all image slots,
   checking assertions and the result summary */

`timescale 1ns/100ps
`default_nettype none

module sd_disk_ctrl_tb;

	localparam int num_slots = 3;
	localparam int req_timeout = 32;

	logic clk_sys;
	logic dd_reset;
	logic [num_slots-1:0] sd_ack;
	sd_disk_pkg::buf_addr_t sd_buff_addr;
	sd_disk_pkg::byte_t sd_buff_dout;
	logic sd_buff_wr;
	logic [num_slots-1:0] img_mounted;
	sd_disk_pkg::img_size_t img_size;
	logic img_readonly;
	logic [num_slots-1:0] req_read;
	logic [num_slots-1:0] req_write;
	sd_disk_pkg::lba_t [num_slots-1:0] host_lba;
	sd_disk_pkg::buf_addr_t [num_slots-1:0] host_addr;
	sd_disk_pkg::byte_t [num_slots-1:0] host_wdata;
	logic [num_slots-1:0] host_we;

	wire [num_slots-1:0] sd_rd;
	wire [num_slots-1:0] sd_wr;
	wire sd_disk_pkg::lba_t [num_slots-1:0] sd_lba;
	wire sd_disk_pkg::byte_t sd_buff_din;
	wire sd_disk_pkg::byte_t [num_slots-1:0] host_rdata;
	wire [num_slots-1:0] disk_mounted;
	wire [num_slots-1:0] disk_protect;
	wire [num_slots-1:0] disk_change;
	wire cpu_wait;

	// Reference state, kept by the stimulus tasks
	sd_disk_pkg::byte_t exp_mem [0:num_slots-1][0:sd_disk_pkg::BUF_DEPTH-1];
	sd_disk_pkg::buf_addr_t touched [$];
	logic [num_slots-1:0] xfer_open;
	logic [num_slots-1:0] ack_last;
	logic [num_slots-1:0] chg_model;
	logic [num_slots-1:0] host_chk;
	sd_disk_pkg::byte_t [num_slots-1:0] host_exp;
	logic sd_chk;
	sd_disk_pkg::byte_t sd_exp;
	integer seed;
	int err_count;
	int timeouts;
	int tests_run;
	int tests_failed;
	int mark;

	sd_disk_ctrl #(.num_slots(num_slots)) UUT (
		.clk_sys(clk_sys),
		.dd_reset(dd_reset),
		.sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr),
		.img_mounted(img_mounted),
		.img_size(img_size),
		.img_readonly(img_readonly),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_lba(sd_lba),
		.sd_buff_din(sd_buff_din),
		.req_read(req_read),
		.req_write(req_write),
		.host_lba(host_lba),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_we(host_we),
		.host_rdata(host_rdata),
		.disk_mounted(disk_mounted),
		.disk_protect(disk_protect),
		.disk_change(disk_change),
		.cpu_wait(cpu_wait)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// A slot is open from its accepted pulse until the SD side drops ack
	always @(posedge clk_sys) begin
		ack_last <= sd_ack;
		if (dd_reset)
			xfer_open <= '0;
		else
			xfer_open <= (xfer_open | req_read | req_write) & ~(ack_last & ~sd_ack);
	end

	// ==============================
	// Checks
	// ==============================

	a_reset_state: assert property (@(posedge clk_sys) $fell(dd_reset) |->
		(sd_rd == '0 && sd_wr == '0 && !cpu_wait && disk_mounted == '0
			&& disk_protect == '0 && disk_change == '0))
	else begin
		err_count++;
		$display("Fail at %0t: outputs not cleared by reset", $time);
	end

	a_sd_readback: assert property (@(posedge clk_sys) disable iff (dd_reset)
		sd_chk |-> ##3 (sd_buff_din == $past(sd_exp, 3)))
	else begin
		err_count++;
		$display("Fail at %0t: sd_buff_din differs from the host written byte", $time);
	end

	for (genvar i = 0; i < num_slots; i++) begin : gen_chk
		a_req_start: assert property (@(posedge clk_sys) disable iff (dd_reset)
			(req_read[i] || req_write[i]) && !xfer_open[i] |->
			##1 !(sd_rd[i] || sd_wr[i])
			##1 (sd_rd[i] == $past(req_read[i], 2) && sd_wr[i] == $past(req_write[i], 2)
				&& cpu_wait && sd_lba[i] == $past(host_lba[i], 2)))
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d request, wait or lba wrong after pulse", $time, i);
		end

		// A repeated pulse during a transfer must not start another one
		a_req_source: assert property (@(posedge clk_sys) disable iff (dd_reset)
			$rose(sd_rd[i] | sd_wr[i]) |->
			($past(req_read[i] | req_write[i], 2) && !$past(xfer_open[i], 2)))
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d raised a request without a new pulse", $time, i);
		end

		a_ack_rise: assert property (@(posedge clk_sys) disable iff (dd_reset)
			$rose(sd_ack[i]) |-> ##2 !(sd_rd[i] || sd_wr[i]))
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d request still high after ack", $time, i);
		end

		a_ack_fall: assert property (@(posedge clk_sys) disable iff (dd_reset)
			$fell(sd_ack[i]) |-> ##1 cpu_wait ##1 !cpu_wait)
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d cpu_wait not released 2 cycles after ack", $time, i);
		end

		a_host_read: assert property (@(posedge clk_sys) disable iff (dd_reset)
			host_chk[i] |=> (host_rdata[i] == $past(host_exp[i])))
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d host_rdata wrong", $time, i);
		end

		a_mount: assert property (@(posedge clk_sys) disable iff (dd_reset)
			img_mounted[i] |-> ##2 (disk_mounted[i] == $past(img_size != '0, 2)
				&& disk_protect[i] == $past(img_readonly, 2)
				&& disk_change[i] == chg_model[i]))
		else begin
			err_count++;
			$display("Fail at %0t: slot %0d mount status wrong", $time, i);
		end
	end

	// Background pattern, distinct per slot and over all nine address bits
	function automatic sd_disk_pkg::byte_t fill_byte(input int slot, input int addr);
		return 8'(addr * 13) ^ 8'(addr >> 8) ^ 8'(slot * 8'h5a);
	endfunction

	task automatic report_test(input string name, input int errs_before);
		repeat (4) @(negedge clk_sys);
		tests_run++;
		if (err_count + timeouts == errs_before) begin
			$display("test %s: ok at %0t", name, $time);
		end else begin
			tests_failed++;
			$display("test %s: failed at %0t", name, $time);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		seed = 32'h4b13;
		err_count = 0;
		timeouts = 0;
		tests_run = 0;
		tests_failed = 0;
		dd_reset = 1'b1;
		sd_ack = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		img_mounted = '0;
		img_size = '0;
		img_readonly = 1'b0;
		req_read = '0;
		req_write = '0;
		host_lba = '0;
		host_addr = '0;
		host_wdata = '0;
		host_we = '0;
		chg_model = '0;
		host_chk = '0;
		host_exp = '0;
		sd_chk = 1'b0;
		sd_exp = '0;
		repeat (3) @(negedge clk_sys);
		dd_reset = 1'b0;
		report_test("reset", 0);

		mark = err_count + timeouts;
		for (int s = 0; s < num_slots; s++) begin
			pulse_request(s, 1'b0, $random(seed));
			serve_read(s, 0, 1'b1);
		end
		report_test("read requests", mark);

		mark = err_count + timeouts;
		preload_buffers();
		for (int s = 0; s < num_slots; s++) begin
			pulse_request(s, 1'b0, 32'(s + 100));
			serve_read(s, 8, 1'b0);
			// Every slot is read back, only slot s may have changed
			for (int c = 0; c < num_slots; c++) begin
				foreach (touched[k])
					host_check(c, touched[k]);
			end
			release_host_port();
			touched.delete();
		end
		report_test("sd to host buffer", mark);

		mark = err_count + timeouts;
		for (int s = 0; s < num_slots; s++) begin
			pulse_request(s, 1'b1, 32'(s + 200));
			for (int k = 0; k < 16; k++) begin
				host_write(s, 9'(k * 31 + s), 8'($random(seed)));
				touched.push_back(9'(k * 31 + s));
			end
			release_host_port();
			serve_write(s);
			touched.delete();
		end
		report_test("host to sd buffer", mark);

		mark = err_count + timeouts;
		for (int s = 0; s < num_slots; s++) begin
			mount_image(s, '0, 1'b1);
			mount_image(s, 64'd143360, 1'b0);
		end
		report_test("mount", mark);

		$display("tests %0d, failed %0d, check errors %0d, timeouts %0d",
			tests_run, tests_failed, err_count, timeouts);
		if (tests_failed == 0 && err_count == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	`include "sd_disk_tb_tasks.svh"

endmodule

`default_nettype wire

//--- verilog/block_channel.sv
/* One image slot: mount status, SD request FSM, sector address latch
   and the dual-port sector buffer shared by host and SD side */

`timescale 1ns/100ps
`default_nettype none

module block_channel (
	input  wire                          clk_sys,
	input  wire                          dd_reset,
	input  wire                          ack,
	input  wire                          buf_we,
	input  wire sd_disk_pkg::buf_addr_t  bus_addr,
	input  wire sd_disk_pkg::byte_t      bus_data,
	input  wire                          mount,
	input  wire                          image_present,
	input  wire                          image_readonly,
	input  wire                          req_read,
	input  wire                          req_write,
	input  wire sd_disk_pkg::lba_t       host_lba,
	input  wire sd_disk_pkg::buf_addr_t  host_addr,
	input  wire sd_disk_pkg::byte_t      host_wdata,
	input  wire                          host_we,
	output logic                         sd_rd,
	output logic                         sd_wr,
	output sd_disk_pkg::lba_t            sd_lba,
	output logic                         wait_req,
	output sd_disk_pkg::byte_t           host_rdata,
	output sd_disk_pkg::byte_t           bus_rdata,
	output logic                         disk_mounted,
	output logic                         disk_protect,
	output logic                         disk_change
);

	sd_disk_pkg::chan_state_t state;
	sd_disk_pkg::chan_state_t state_next;
	logic rd_pend;
	logic wr_pend;
	logic ack_d;
	logic ack_rise;
	logic ack_fall;
	logic req_take;
	sd_disk_pkg::byte_t buf_mem [0:sd_disk_pkg::BUF_DEPTH-1];

	// ==============================
	// Request FSM
	// ==============================

	assign ack_rise = ack & ~ack_d;
	assign ack_fall = ~ack & ack_d;

	// New requests only while nothing is queued or in flight
	assign req_take = (state == sd_disk_pkg::chan_idle) & ~rd_pend & ~wr_pend;

	always_comb begin
		state_next = state;
		case (state)
			sd_disk_pkg::chan_idle: begin
				if (rd_pend | wr_pend)
					state_next = sd_disk_pkg::chan_busy;
			end
			sd_disk_pkg::chan_busy: begin
				if (ack_fall)
					state_next = sd_disk_pkg::chan_idle;
			end
			default: state_next = sd_disk_pkg::chan_idle;
		endcase
	end

	// Taken from the next state so the stall lines up after the merge register
	assign wait_req = (state_next == sd_disk_pkg::chan_busy);

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state <= sd_disk_pkg::chan_idle;
			ack_d <= 1'b0;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end else begin
			state <= state_next;
			ack_d <= ack;
			if (req_take) begin
				rd_pend <= req_read;
				wr_pend <= req_write;
			end
			if (state == sd_disk_pkg::chan_idle && (rd_pend || wr_pend)) begin
				sd_rd <= rd_pend;
				sd_wr <= wr_pend;
			end else if (state == sd_disk_pkg::chan_busy && ack_rise) begin
				// Host has taken the request
				rd_pend <= 1'b0;
				wr_pend <= 1'b0;
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_take && (req_read || req_write))
			sd_lba <= host_lba;
	end

	// ==============================
	// Mount status
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			disk_mounted <= 1'b0;
			disk_protect <= 1'b0;
			disk_change <= 1'b0;
		end else if (mount) begin
			disk_mounted <= image_present;
			disk_protect <= image_readonly;
			disk_change <= ~disk_change;
		end
	end

	// ==============================
	// Sector buffer
	// ==============================

	// SD side port
	always @(posedge clk_sys) begin
		if (buf_we)
			buf_mem[bus_addr] <= bus_data;
		bus_rdata <= buf_mem[bus_addr];
	end

	// Host side port
	always @(posedge clk_sys) begin
		if (host_we)
			buf_mem[host_addr] <= host_wdata;
		host_rdata <= buf_mem[host_addr];
	end

	a_req_in_busy: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(sd_rd || sd_wr) |-> (state == sd_disk_pkg::chan_busy));

	a_wait_idle: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(state == sd_disk_pkg::chan_idle && !(rd_pend || wr_pend)) |-> !wait_req);

endmodule

`default_nettype wire

//--- verilog/sd_bus_fanout.sv
/* SD bus input register with per-slot buffer write strobes and mount strobes */

`timescale 1ns/100ps
`default_nettype none

module sd_bus_fanout #(
	parameter int num_slots = sd_disk_pkg::NUM_SLOTS
) (
	input  wire                           clk_sys,
	input  wire                           dd_reset,
	input  wire        [num_slots-1:0]    sd_ack,
	input  wire sd_disk_pkg::buf_addr_t   sd_buff_addr,
	input  wire sd_disk_pkg::byte_t       sd_buff_dout,
	input  wire                           sd_buff_wr,
	input  wire        [num_slots-1:0]    img_mounted,
	input  wire sd_disk_pkg::img_size_t   img_size,
	input  wire                           img_readonly,
	output logic       [num_slots-1:0]    slot_ack,
	output logic       [num_slots-1:0]    slot_buf_we,
	output sd_disk_pkg::buf_addr_t        bus_addr,
	output sd_disk_pkg::byte_t            bus_data,
	output logic       [num_slots-1:0]    slot_mount,
	output logic                          image_present,
	output logic                          image_readonly
);

	// ==============================
	// Control strobes
	// ==============================

	// The bus is shared, so a write only lands in the buffer of the acked slot
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			slot_ack <= '0;
			slot_buf_we <= '0;
			slot_mount <= '0;
		end else begin
			slot_ack <= sd_ack;
			slot_buf_we <= sd_ack & {num_slots{sd_buff_wr}};
			slot_mount <= img_mounted;
		end
	end

	// ==============================
	// Payload
	// ==============================

	// Image info is only looked at together with slot_mount
	always_ff @(posedge clk_sys) begin
		bus_addr <= sd_buff_addr;
		bus_data <= sd_buff_dout;
		image_present <= (img_size != '0);
		image_readonly <= img_readonly;
	end

	// The host services one slot at a time
	a_ack_onehot: assert property (@(posedge clk_sys) disable iff (dd_reset)
		$onehot0(sd_ack));

endmodule

`default_nettype wire

//--- verilog/sd_bus_merge.sv
/* Registered SD read-back mux over the acked slot and the CPU wait OR */

`timescale 1ns/100ps
`default_nettype none

module sd_bus_merge #(
	parameter int num_slots = sd_disk_pkg::NUM_SLOTS
) (
	input  wire                                    clk_sys,
	input  wire                                    dd_reset,
	input  wire        [num_slots-1:0]             slot_ack,
	input  wire sd_disk_pkg::byte_t [num_slots-1:0] slot_rdata,
	input  wire        [num_slots-1:0]             slot_wait,
	output sd_disk_pkg::byte_t                     sd_buff_din,
	output logic                                   cpu_wait
);

	logic [num_slots-1:0] ack_d;
	sd_disk_pkg::byte_t rdata_sel;

	// ==============================
	// Read-back path
	// ==============================

	// slot_rdata is one buffer read behind slot_ack, so the ack is delayed
	// once more to select the matching byte
	always_ff @(posedge clk_sys) begin
		if (dd_reset)
			ack_d <= '0;
		else
			ack_d <= slot_ack;
	end

	// At most one slot is acked, zero when none
	always_comb begin
		rdata_sel = '0;
		for (int i = 0; i < num_slots; i++) begin
			if (ack_d[i])
				rdata_sel = rdata_sel | slot_rdata[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		sd_buff_din <= rdata_sel;
	end

	// ==============================
	// CPU stall
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (dd_reset)
			cpu_wait <= 1'b0;
		else
			cpu_wait <= |slot_wait;
	end

endmodule

`default_nettype wire

//--- verilog/sd_disk_ctrl.sv
/* Block device glue top: SD bus fan-out, one channel per image slot, merge */

`timescale 1ns/100ps
`default_nettype none

module sd_disk_ctrl #(
	parameter int num_slots = sd_disk_pkg::NUM_SLOTS
) (
	input  wire                                        clk_sys,
	input  wire                                        dd_reset,
	// SD block service
	input  wire        [num_slots-1:0]                 sd_ack,
	input  wire sd_disk_pkg::buf_addr_t                sd_buff_addr,
	input  wire sd_disk_pkg::byte_t                    sd_buff_dout,
	input  wire                                        sd_buff_wr,
	input  wire        [num_slots-1:0]                 img_mounted,
	input  wire sd_disk_pkg::img_size_t                img_size,
	input  wire                                        img_readonly,
	output wire        [num_slots-1:0]                 sd_rd,
	output wire        [num_slots-1:0]                 sd_wr,
	output wire sd_disk_pkg::lba_t [num_slots-1:0]     sd_lba,
	output wire sd_disk_pkg::byte_t                    sd_buff_din,
	// Emulated machine side
	input  wire        [num_slots-1:0]                 req_read,
	input  wire        [num_slots-1:0]                 req_write,
	input  wire sd_disk_pkg::lba_t [num_slots-1:0]     host_lba,
	input  wire sd_disk_pkg::buf_addr_t [num_slots-1:0] host_addr,
	input  wire sd_disk_pkg::byte_t [num_slots-1:0]    host_wdata,
	input  wire        [num_slots-1:0]                 host_we,
	output wire sd_disk_pkg::byte_t [num_slots-1:0]    host_rdata,
	// Status
	output wire        [num_slots-1:0]                 disk_mounted,
	output wire        [num_slots-1:0]                 disk_protect,
	output wire        [num_slots-1:0]                 disk_change,
	output wire                                        cpu_wait
);

	wire [num_slots-1:0] slot_ack;
	wire [num_slots-1:0] slot_buf_we;
	wire [num_slots-1:0] slot_mount;
	wire [num_slots-1:0] slot_wait;
	wire sd_disk_pkg::buf_addr_t bus_addr;
	wire sd_disk_pkg::byte_t bus_data;
	wire sd_disk_pkg::byte_t [num_slots-1:0] slot_rdata;
	wire image_present;
	wire image_readonly;

	sd_bus_fanout #(.num_slots(num_slots)) fanout (
		.clk_sys(clk_sys),
		.dd_reset(dd_reset),
		.sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr),
		.img_mounted(img_mounted),
		.img_size(img_size),
		.img_readonly(img_readonly),
		.slot_ack(slot_ack),
		.slot_buf_we(slot_buf_we),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.slot_mount(slot_mount),
		.image_present(image_present),
		.image_readonly(image_readonly)
	);

	// Slot 0 floppy 1, slot 1 hard disk, slot 2 floppy 2
	for (genvar g = 0; g < num_slots; g++) begin : gen_slot
		block_channel chan (
			.clk_sys(clk_sys),
			.dd_reset(dd_reset),
			.ack(slot_ack[g]),
			.buf_we(slot_buf_we[g]),
			.bus_addr(bus_addr),
			.bus_data(bus_data),
			.mount(slot_mount[g]),
			.image_present(image_present),
			.image_readonly(image_readonly),
			.req_read(req_read[g]),
			.req_write(req_write[g]),
			.host_lba(host_lba[g]),
			.host_addr(host_addr[g]),
			.host_wdata(host_wdata[g]),
			.host_we(host_we[g]),
			.sd_rd(sd_rd[g]),
			.sd_wr(sd_wr[g]),
			.sd_lba(sd_lba[g]),
			.wait_req(slot_wait[g]),
			.host_rdata(host_rdata[g]),
			.bus_rdata(slot_rdata[g]),
			.disk_mounted(disk_mounted[g]),
			.disk_protect(disk_protect[g]),
			.disk_change(disk_change[g])
		);
	end

	sd_bus_merge #(.num_slots(num_slots)) merge (
		.clk_sys(clk_sys),
		.dd_reset(dd_reset),
		.slot_ack(slot_ack),
		.slot_rdata(slot_rdata),
		.slot_wait(slot_wait),
		.sd_buff_din(sd_buff_din),
		.cpu_wait(cpu_wait)
	);

endmodule

`default_nettype wire

//--- verilog/sd_disk_pkg.sv
/* Shared widths, slot count and sector address, buffer and image size types,
   plus the per-slot channel state encoding */

`default_nettype none

package sd_disk_pkg;

	// ==============================
	// Widths and counts
	// ==============================

	// Floppy 1, hard disk, floppy 2
	localparam int NUM_SLOTS = 3;

	localparam int LBA_W = 32;
	localparam int BUF_AW = 9;
	localparam int BYTE_W = 8;
	localparam int SIZE_W = 64;

	// One SD sector per slot
	localparam int BUF_DEPTH = 1 << BUF_AW;

	// ==============================
	// Types
	// ==============================

	typedef logic [LBA_W-1:0] lba_t;
	typedef logic [BUF_AW-1:0] buf_addr_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [SIZE_W-1:0] img_size_t;

	// Request machine of one slot
	// chan_busy lasts from sd_rd/sd_wr until the ack has dropped again
	typedef enum logic {
		chan_idle = 1'b0,
		chan_busy = 1'b1
	} chan_state_t;

endpackage

`default_nettype wire
